/* hdl/mem_sys_params.svh */
/*
 * Cache memory system parameters. Address split, line geometry and
 * main memory bank timing
 */
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

// Byte address = tag | index | offset
`define MS_TAG_W      5
`define MS_IDX_W      8
`define MS_OFS_W      3

`define MS_WORDS      4     // Words per line
`define MS_BANKS      4

`define MS_MEM_LAT    2     // Read issue to data
`define MS_BANK_BUSY  4
`define MS_MEM_DEPTH  2048  // Words, low address bits only

`endif

/* hdl/mem_sys_pkg.sv */
/*
 * Cache memory system types. Controller states and address fields
 */
`default_nettype none
`include "mem_sys_params.svh"

package mem_sys_pkg;

   typedef enum logic [2:0] {
      IDLE, COMPARE, WB_ISSUE, FILL_ISSUE, FILL_WAIT, REFILL_DONE, DONE
   } ctrl_state_t;

   typedef logic [`MS_TAG_W-1:0]         tag_t;
   typedef logic [`MS_IDX_W-1:0]         idx_t;
   typedef logic [$clog2(`MS_WORDS)-1:0] wsel_t;  // Word within a line
   typedef logic [15:0]                  word_t;

endpackage

`default_nettype wire

/* hdl/cache_if.sv */
/*
 * Controller to cache array bundle
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_sys_params.svh"

interface cache_if;
   logic                         en;
   logic                         comp;      // Compare access, else raw
   logic                         write;
   logic                         valid_in;
   logic [`MS_IDX_W-1:0]         idx;
   logic [`MS_TAG_W-1:0]         tag;
   logic [$clog2(`MS_WORDS)-1:0] word_sel;
   logic [15:0]                  wdata;

   logic [15:0]                  rdata;
   logic [`MS_TAG_W-1:0]         tag_out;   // Tag stored at idx
   logic                         hit;
   logic                         dirty;
   logic                         valid;

   modport ctrl (output en, comp, write, valid_in, idx, tag, word_sel, wdata,
                 input  rdata, tag_out, hit, dirty, valid);

   modport array (input  en, comp, write, valid_in, idx, tag, word_sel, wdata,
                  output rdata, tag_out, hit, dirty, valid);
endinterface

`default_nettype wire

/* hdl/mem_if.sv */
/*
 * Controller to banked main memory bundle
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_if;
   logic [15:0] addr;     // Byte address
   logic [15:0] wdata;
   logic        rd;
   logic        wr;

   logic [15:0] rdata;
   logic        rvalid;
   logic        stall;    // Addressed bank busy

   modport ctrl (output addr, wdata, rd, wr,
                 input  rdata, rvalid, stall);

   modport mem (input  addr, wdata, rd, wr,
                output rdata, rvalid, stall);
endinterface

`default_nettype wire

/* hdl/burst_counter.sv */
/*
 * Line burst counters. Tracks issued and returned words separately
 * so reads may overlap
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_sys_params.svh"

module burst_counter
   import mem_sys_pkg::*;
(
   input  wire   clk,
   input  wire   arst_n,
   input  wire   clear,
   input  wire   issue,
   input  wire   ret,
   output wsel_t issue_idx,
   output wsel_t ret_idx,
   output logic  issue_last,
   output logic  ret_last
);
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         issue_idx <= '0;
         ret_idx   <= '0;
      end else if (clear) begin
         issue_idx <= '0;
         ret_idx   <= '0;
      end else begin
         if (issue) issue_idx <= issue_idx + 1'b1;  // Wraps after a full line
         if (ret)   ret_idx   <= ret_idx + 1'b1;
      end
   end

   assign issue_last = (issue_idx == wsel_t'(`MS_WORDS - 1));
   assign ret_last   = (ret_idx == wsel_t'(`MS_WORDS - 1));
endmodule

`default_nettype wire

/* hdl/cache_array.sv */
/*
 * Direct-mapped cache storage. Tag, valid, dirty and line data,
 * combinational lookup and tag compare
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_sys_params.svh"

module cache_array
   import mem_sys_pkg::*;
(
   input wire     clk,
   input wire     arst_n,
   cache_if.array cif
);
   localparam int LINES = 1 << `MS_IDX_W;

   tag_t             tag_mem  [LINES];
   word_t            data_mem [LINES][`MS_WORDS];
   logic [LINES-1:0] valid_q;
   logic [LINES-1:0] dirty_q;
   logic             raw_wr, cmp_wr;

   assign cif.tag_out = tag_mem[cif.idx];
   assign cif.rdata   = data_mem[cif.idx][cif.word_sel];
   assign cif.valid   = valid_q[cif.idx];
   assign cif.dirty   = dirty_q[cif.idx];
   assign cif.hit     = cif.en & valid_q[cif.idx] & (tag_mem[cif.idx] == cif.tag);

   assign raw_wr = cif.en & cif.write & !cif.comp;
   assign cmp_wr = cif.write & !cif.comp ? 1'b0 : cif.write & cif.hit;  // Only on a hit

   always_ff @(posedge clk) begin
      if (raw_wr || cmp_wr)
         data_mem[cif.idx][cif.word_sel] <= cif.wdata;
      if (raw_wr)
         tag_mem[cif.idx] <= cif.tag;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (cmp_wr) begin
         dirty_q[cif.idx] <= 1'b1;
      end else if (raw_wr && cif.valid_in) begin
         valid_q[cif.idx] <= 1'b1;  // Fresh from memory
         dirty_q[cif.idx] <= 1'b0;
      end
   end
endmodule

`default_nettype wire

/* hdl/banked_mem.sv */
/*
 * Four-bank word-interleaved main memory. Fixed read latency and
 * a busy window per bank after each access
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_sys_params.svh"

module banked_mem
   import mem_sys_pkg::*;
(
   input wire clk,
   input wire arst_n,
   mem_if.mem mif
);
   localparam int ROWS   = `MS_MEM_DEPTH / `MS_BANKS;
   localparam int BANK_W = $clog2(`MS_BANKS);
   localparam int ROW_W  = $clog2(ROWS);
   localparam int CNT_W  = $clog2(`MS_BANK_BUSY + 1);
   localparam int LAT    = `MS_MEM_LAT;

   word_t             mem [`MS_BANKS][ROWS] = '{default: '0};
   logic [CNT_W-1:0]  busy_cnt [`MS_BANKS];
   word_t             rdata_pipe [LAT];
   logic [LAT-1:0]    rvalid_pipe;
   logic [BANK_W-1:0] bank;
   logic [ROW_W-1:0]  row;
   logic              take_rd, take_wr;

   assign bank       = mif.addr[1 +: BANK_W];  // Low word address bits
   assign row        = mif.addr[1 + BANK_W +: ROW_W];
   assign mif.stall  = (busy_cnt[bank] != '0);
   assign take_rd    = mif.rd & ~mif.stall;
   assign take_wr    = mif.wr & ~mif.stall;
   assign mif.rdata  = rdata_pipe[LAT-1];
   assign mif.rvalid = rvalid_pipe[LAT-1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < `MS_BANKS; b++) busy_cnt[b] <= '0;
         rvalid_pipe <= '0;
      end else begin
         for (int b = 0; b < `MS_BANKS; b++) begin
            if ((take_rd || take_wr) && bank == BANK_W'(b))
               busy_cnt[b] <= CNT_W'(`MS_BANK_BUSY);
            else if (busy_cnt[b] != '0)
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
         rvalid_pipe <= (rvalid_pipe << 1) | LAT'(take_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (take_wr) mem[bank][row] <= mif.wdata;
      rdata_pipe[0] <= mem[bank][row];
      for (int s = 1; s < LAT; s++) rdata_pipe[s] <= rdata_pipe[s-1];
   end
endmodule

`default_nettype wire

/* hdl/cache_ctrl_fsm.sv */
/*
 * Cache controller. Sequences hit lookups, dirty line writeback and
 * line refill, and holds the last read result
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_sys_params.svh"

module cache_ctrl_fsm
   import mem_sys_pkg::*;
(
   input  wire         clk,
   input  wire         arst_n,
   input  wire  word_t addr,
   input  wire  word_t wdata,
   input  wire         rd,
   input  wire         wr,
   cache_if.ctrl       cif,
   mem_if.ctrl         mif,
   output logic        clear,
   output logic        issue,
   output logic        ret,
   input  wire  wsel_t issue_idx,
   input  wire  wsel_t ret_idx,
   input  wire         issue_last,
   input  wire         ret_last,
   output word_t       rdata,
   output logic        done,
   output logic        busy,
   output logic        hit,
   output logic        err
);
   ctrl_state_t state, state_nxt, start_nxt;
   word_t       addr_q, wdata_q, rdata_q;
   logic        rd_q, wr_q, err_q;
   logic        req, bad;
   tag_t        tag_q;
   idx_t        idx_q;
   wsel_t       wsel_q;

   assign tag_q  = addr_q[15 -: `MS_TAG_W];
   assign idx_q  = addr_q[`MS_OFS_W +: `MS_IDX_W];
   assign wsel_q = addr_q[`MS_OFS_W-1:1];

   // A hit finishes in COMPARE, so the next request may land there
   assign busy  = (state == COMPARE) ? !cif.hit : (state != IDLE && state != DONE);
   assign req   = (rd | wr) & ~busy;
   assign bad   = (rd & wr) | addr[0];
   assign start_nxt = !req ? IDLE : (bad ? DONE : COMPARE);

   assign hit   = (state == COMPARE) & cif.hit;
   assign done  = (state == DONE) | hit;
   assign err   = (state == DONE) & err_q;
   assign rdata = (hit && rd_q) ? cif.rdata : rdata_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) state <= IDLE;
      else         state <= state_nxt;
   end

   always_ff @(posedge clk) begin
      if (req) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         rd_q    <= rd;
         wr_q    <= wr;
         err_q   <= bad;
      end
      if (rd_q && (hit || state == REFILL_DONE))
         rdata_q <= cif.rdata;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, DONE: state_nxt = start_nxt;
         COMPARE:
            if (cif.hit)                     state_nxt = start_nxt;
            else if (cif.valid && cif.dirty) state_nxt = WB_ISSUE;
            else                             state_nxt = FILL_ISSUE;
         WB_ISSUE:   if (issue && issue_last) state_nxt = FILL_ISSUE;
         FILL_ISSUE: if (issue && issue_last) state_nxt = FILL_WAIT;
         FILL_WAIT:  if (ret && ret_last)     state_nxt = REFILL_DONE;
         REFILL_DONE: state_nxt = DONE;
         default:     state_nxt = IDLE;
      endcase
   end

   always_comb begin
      cif.en       = 1'b0;
      cif.comp     = 1'b0;
      cif.write    = 1'b0;
      cif.valid_in = 1'b0;
      cif.idx      = idx_q;
      cif.tag      = tag_q;
      cif.word_sel = wsel_q;
      cif.wdata    = wdata_q;
      mif.addr     = {tag_q, idx_q, issue_idx, 1'b0};
      mif.wdata    = cif.rdata;
      mif.rd       = 1'b0;
      mif.wr       = 1'b0;
      clear        = (state == COMPARE);
      issue        = 1'b0;
      ret          = 1'b0;
      case (state)
         COMPARE, REFILL_DONE: begin
            cif.en    = 1'b1;
            cif.comp  = 1'b1;
            cif.write = wr_q;  // Array drops it on a miss
         end
         WB_ISSUE: begin
            cif.en       = 1'b1;
            cif.word_sel = issue_idx;
            mif.addr     = {cif.tag_out, idx_q, issue_idx, 1'b0};  // Victim line
            mif.wr       = 1'b1;
            issue        = !mif.stall;
         end
         FILL_ISSUE, FILL_WAIT: begin
            cif.en       = mif.rvalid;  // Returns go straight into the line
            cif.write    = 1'b1;
            cif.valid_in = 1'b1;
            cif.word_sel = ret_idx;
            cif.wdata    = mif.rdata;
            mif.rd       = (state == FILL_ISSUE);
            issue        = mif.rd & !mif.stall;
            ret          = mif.rvalid;
         end
         default: ;
      endcase
   end
endmodule

`default_nettype wire

/* hdl/mem_system.sv */
/*
 * Cache memory system top. Write-back direct-mapped cache in front
 * of a four-bank main memory
 */
`timescale 1ns/1ps
`default_nettype none

module mem_system
   import mem_sys_pkg::*;
(
   input  wire   clk,
   input  wire   arst_n,
   input  wire   word_t addr,
   input  wire   word_t wdata,
   input  wire   rd,
   input  wire   wr,
   output word_t rdata,
   output logic  done,
   output logic  busy,
   output logic  hit,
   output logic  err
);
   wire   clear, issue, ret;
   wsel_t issue_idx, ret_idx;
   wire   issue_last, ret_last;

   cache_if cif ();
   mem_if   mif ();

   cache_ctrl_fsm i_ctrl (
      .clk, .arst_n, .addr, .wdata, .rd, .wr,
      .cif        (cif.ctrl),
      .mif        (mif.ctrl),
      .clear, .issue, .ret,
      .issue_idx, .ret_idx, .issue_last, .ret_last,
      .rdata, .done, .busy, .hit, .err
   );

   burst_counter i_burst (
      .clk, .arst_n, .clear, .issue, .ret,
      .issue_idx, .ret_idx, .issue_last, .ret_last
   );

   cache_array i_cache (.clk, .arst_n, .cif(cif.array));

   banked_mem i_mem (.clk, .arst_n, .mif(mif.mem));
endmodule

`default_nettype wire

/* tests/tb_mem_system.sv */
/*
 * Testbench for the cache memory system. Replays accesses from the
 * stim file and checks read data, hit and err at each done
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;
   localparam int TIMEOUT = 200;  // Cycles allowed per access

   logic        clk = 1'b0;
   logic        arst_n;
   logic [15:0] addr;
   logic [15:0] wdata;
   logic        rd;
   logic        wr;
   wire  [15:0] rdata;
   wire         done, busy, hit, err;

   int          errors = 0;
   int          tests = 0;
   bit          stuck = 1'b0;

   mem_system i_dut (
      .clk, .arst_n, .addr, .wdata, .rd, .wr,
      .rdata, .done, .busy, .hit, .err
   );

   always #20 clk = ~clk;

   // Op 0 reads, op 1 writes, op 2 drives both strobes
   task automatic run_access(input logic [3:0] op, input logic [15:0] a,
                             input logic [15:0] wd, input logic [15:0] exp_data,
                             input logic exp_hit);
      int   cycles;
      int   errs_before;
      logic exp_err;
      errs_before = errors;
      exp_err = (op == 4'd2) || a[0];  // Both strobes or odd address
      @(negedge clk);
      addr  = a;
      wdata = wd;
      rd    = (op != 4'd1);
      wr    = (op != 4'd0);
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
      cycles = 0;
      while (!done && cycles < TIMEOUT) begin
         if (!busy) begin
            $display("Error at %0t ns: busy is %b, expected 1", $time, busy);
            errors++;
         end
         @(negedge clk);
         cycles++;
      end
      if (!done) begin
         $display("Access to address %h did not finish within %0d cycles", a, TIMEOUT);
         stuck = 1'b1;
         errors++;
      end else begin
         if ((exp_hit || exp_err) && cycles != 0) begin
            $display("Error at %0t ns: done latency is %0d cycles, expected 1",
                     $time, cycles + 1);
            errors++;
         end
         if (err !== exp_err) begin
            $display("Error at %0t ns: err is %b, expected %b", $time, err, exp_err);
            errors++;
         end
         if (hit !== exp_hit) begin
            $display("Error at %0t ns: hit is %b, expected %b", $time, hit, exp_hit);
            errors++;
         end
         if (op == 4'd0 && !exp_err && rdata !== exp_data) begin
            $display("Error at %0t ns: rdata is %h, expected %h", $time, rdata, exp_data);
            errors++;
         end
      end
      tests++;
      $display("Test %0d: op %0d addr %h %s", tests, op, a,
               (errors == errs_before) ? "ok" : "mismatch");
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      logic [3:0]  op;
      logic [15:0] a;
      logic [15:0] wd;
      logic [15:0] exp_data;
      logic [3:0]  exp_hit;
      arst_n = 1'b0;
      rd     = 1'b0;
      wr     = 1'b0;
      addr   = '0;
      wdata  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      fd = $fopen("tests/mem_system_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file tests/mem_system_stim.txt");
         errors++;
      end else begin
         while (!stuck && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h", op, a, wd, exp_data, exp_hit);
            if (n == 5) begin
               run_access(op, a, wd, exp_data, exp_hit[0]);
            end else if (n > 0) begin
               $display("Stimulus line has %0d of 5 fields: %s", n, line);
               errors++;
            end
         end
         $fclose(fd);
      end
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end
endmodule

`default_nettype wire

/* tests/mem_system_stim.txt */
// op (0 read, 1 write, 2 read and write), byte address, write data,
// expected read data, expected hit; all fields hex
0 0010 0000 0000 0
0 0010 0000 0000 1
1 0012 a1b2 0000 1
0 0012 0000 a1b2 1
1 0014 c3d4 0000 1
1 0016 e5f6 0000 1
1 0010 1357 0000 1
1 0810 2468 0000 0
0 0816 0000 0000 1
0 0012 0000 a1b2 0
0 0010 0000 1357 1
0 0014 0000 c3d4 1
0 0016 0000 e5f6 1
0 0810 0000 2468 0
0 0011 0000 0000 0
2 0818 5555 0000 0
1 0811 7777 0000 0
0 0812 0000 0000 1
0 0810 0000 2468 1
0 0100 0000 0000 0
1 0102 beef 0000 1
0 0102 0000 beef 1
0 0f00 0000 0000 0

/* project.f */
+incdir+hdl
hdl/mem_sys_pkg.sv
hdl/cache_if.sv
hdl/mem_if.sv
hdl/burst_counter.sv
hdl/cache_array.sv
hdl/banked_mem.sv
hdl/cache_ctrl_fsm.sv
hdl/mem_system.sv
tests/tb_mem_system.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary -Wno-fatal
TOP      ?= tb_mem_system
FILELIST ?= project.f

SOURCES  := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
